//--- Bender.yml
package:
  name: scene_memory

sources:
  - files:
      - design/scene_pkg.sv
      - design/scene_bank_ram.sv
      - design/scene_update_pipe.sv
      - design/frame_sequencer.sv
      - design/scene_double_bank.sv
      - design/scene_memory.sv
  - target: test
    files:
      - tb/scene_memory_checker.sv
      - tb/tb_scene_memory.sv

//--- compile.f
design/scene_pkg.sv
design/scene_bank_ram.sv
design/scene_update_pipe.sv
design/frame_sequencer.sv
design/scene_double_bank.sv
design/scene_memory.sv
tb/scene_memory_checker.sv
tb/tb_scene_memory.sv

//--- design/frame_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

// Acts on frame and render commands in the merge stage
module frame_sequencer (
    input  wire                     clk_100mhz,
    input  wire                     rst,
    input  wire                     s2_valid,
    input  wire scene_pkg::opcode_e s2_op,
    input  wire                     controller_busy,
    output logic                    stall,
    output logic                    write_bank,
    output logic                    issue_bank,     // write_bank after this cycle
    output logic                    output_enabled
);

    logic is_frame;
    logic is_render;

    assign is_frame  = s2_valid && s2_op == scene_pkg::op_frame;
    assign is_render = s2_valid && s2_op == scene_pkg::op_render;

    // Hold the whole pipe until the renderer is free
    assign stall = (is_frame || is_render) && controller_busy;

    assign issue_bank = write_bank ^ (is_frame && !controller_busy);

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            write_bank     <= 1'b0;
            output_enabled <= 1'b0;
        end else begin
            write_bank <= issue_bank;  // Swap only, no copy
            if (is_frame && !controller_busy) begin
                output_enabled <= 1'b1;
            end else if (is_render && !controller_busy) begin
                output_enabled <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/scene_bank_ram.sv
`default_nettype none
`timescale 1ns/1ps

// Port A reads at a_addr and writes at a_wr_addr in the same cycle
module scene_bank_ram #(
    parameter int width = 130,
    parameter int depth = 8
) (
    input  wire                      clk_100mhz,
    input  wire                      a_en,       // Update read enable
    input  wire  [$clog2(depth)-1:0] a_addr,
    input  wire                      a_we,
    input  wire  [$clog2(depth)-1:0] a_wr_addr,
    input  wire  [width-1:0]         a_din,
    input  wire  [$clog2(depth)-1:0] b_addr,     // Display read
    output logic [width-1:0]         a_dout,
    output logic [width-1:0]         b_dout
);

    logic [width-1:0] mem [depth] = '{default: '0};

    always_ff @(posedge clk_100mhz) begin
        if (a_en) begin
            a_dout <= mem[a_addr];  // Read first, a colliding write shows next cycle
        end
        if (a_we) begin
            mem[a_wr_addr] <= a_din;
        end
        b_dout <= mem[b_addr];
    end

endmodule

`default_nettype wire

//--- design/scene_double_bank.sv
`default_nettype none
`timescale 1ns/1ps

module scene_double_bank #(
    parameter int num_lights = scene_pkg::NUM_LIGHTS_DEFAULT
) (
    input  wire                           clk_100mhz,
    input  wire                           rst,
    input  wire                           write_bank,  // Display uses the other one
    input  wire                           rd_en,
    input  wire                           rd_bank,
    input  wire  [$clog2(num_lights)-1:0] rd_addr,
    input  wire                           light_we,
    input  wire                           camera_we,
    input  wire                           wr_bank,
    input  wire  [$clog2(num_lights)-1:0] wr_addr,
    input  wire scene_pkg::light_t        light_wr_data,
    input  wire scene_pkg::camera_t       camera_wr_data,
    input  wire  [$clog2(num_lights)-1:0] light_read_addr,
    output scene_pkg::light_t             light_rd_data,
    output scene_pkg::camera_t            camera_rd_data,
    output scene_pkg::light_t             light_output,
    output scene_pkg::camera_t            camera_output
);

    scene_pkg::light_t  ram_a_dout [2];
    scene_pkg::light_t  ram_b_dout [2];
    scene_pkg::camera_t camera_reg [2];
    logic               rd_bank_q;    // Bank behind light_rd_data
    logic               disp_bank_q;  // Bank behind light_output

    for (genvar i = 0; i < 2; i++) begin : g_bank
        scene_bank_ram #(
            .width ($bits(scene_pkg::light_t)),
            .depth (num_lights)
        ) u_light_ram (
            .clk_100mhz (clk_100mhz),
            .a_en       (rd_en && rd_bank == 1'(i)),
            .a_addr     (rd_addr),
            .a_we       (light_we && wr_bank == 1'(i)),
            .a_wr_addr  (wr_addr),
            .a_din      (light_wr_data),
            .b_addr     (light_read_addr),
            .a_dout     (ram_a_dout[i]),
            .b_dout     (ram_b_dout[i])
        );
    end

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            camera_reg[0] <= '0;
            camera_reg[1] <= '0;
            rd_bank_q     <= 1'b0;
            disp_bank_q   <= 1'b1;
        end else begin
            if (camera_we) begin
                camera_reg[wr_bank] <= camera_wr_data;
            end
            if (rd_en) begin
                rd_bank_q <= rd_bank;
            end
            disp_bank_q <= !write_bank;
        end
    end

    // Camera reads, old value on a same-cycle write
    always_ff @(posedge clk_100mhz) begin
        if (rd_en) begin
            camera_rd_data <= camera_reg[rd_bank];
        end
        camera_output <= camera_reg[!write_bank];
    end

    assign light_rd_data = ram_a_dout[rd_bank_q];
    assign light_output  = ram_b_dout[disp_bank_q];

endmodule

`default_nettype wire

//--- design/scene_memory.sv
`default_nettype none
`timescale 1ns/1ps

module scene_memory #(
    parameter int num_lights = scene_pkg::NUM_LIGHTS_DEFAULT
) (
    input  wire                              clk_100mhz,
    input  wire                              rst,
    input  wire                              inst_valid,
    input  wire scene_pkg::opcode_e          inst_op,
    input  wire  [scene_pkg::PROP_WIDTH-1:0] inst_prop,
    input  wire  [$clog2(num_lights)-1:0]    inst_index,
    input  wire  [scene_pkg::DATA_WIDTH-1:0] inst_data,
    input  wire                              controller_busy,
    input  wire  [$clog2(num_lights)-1:0]    light_read_addr,
    output logic                             stall,           // Source holds instruction
    output logic                             output_enabled,
    output scene_pkg::camera_t               camera_output,
    output scene_pkg::light_t                light_output
);

    logic                          rd_en;
    logic                          rd_bank;
    logic [$clog2(num_lights)-1:0] rd_addr;
    logic                          s2_valid;
    scene_pkg::opcode_e            s2_op;
    logic                          light_we;
    logic                          camera_we;
    logic                          wr_bank;
    logic [$clog2(num_lights)-1:0] wr_addr;
    logic                          write_bank;
    logic                          issue_bank;
    scene_pkg::light_t             light_rd_data;
    scene_pkg::light_t             light_wr_data;
    scene_pkg::camera_t            camera_rd_data;
    scene_pkg::camera_t            camera_wr_data;

    scene_update_pipe #(
        .num_lights (num_lights)
    ) u_scene_update_pipe (
        .clk_100mhz     (clk_100mhz),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst_op        (inst_op),
        .inst_prop      (inst_prop),
        .inst_index     (inst_index),
        .inst_data      (inst_data),
        .stall          (stall),
        .issue_bank     (issue_bank),
        .light_rd_data  (light_rd_data),
        .camera_rd_data (camera_rd_data),
        .rd_en          (rd_en),
        .rd_bank        (rd_bank),
        .rd_addr        (rd_addr),
        .s2_valid       (s2_valid),
        .s2_op          (s2_op),
        .light_we       (light_we),
        .camera_we      (camera_we),
        .wr_bank        (wr_bank),
        .wr_addr        (wr_addr),
        .light_wr_data  (light_wr_data),
        .camera_wr_data (camera_wr_data)
    );

    scene_double_bank #(
        .num_lights (num_lights)
    ) u_scene_double_bank (
        .clk_100mhz      (clk_100mhz),
        .rst             (rst),
        .write_bank      (write_bank),
        .rd_en           (rd_en),
        .rd_bank         (rd_bank),
        .rd_addr         (rd_addr),
        .light_we        (light_we),
        .camera_we       (camera_we),
        .wr_bank         (wr_bank),
        .wr_addr         (wr_addr),
        .light_wr_data   (light_wr_data),
        .camera_wr_data  (camera_wr_data),
        .light_read_addr (light_read_addr),
        .light_rd_data   (light_rd_data),
        .camera_rd_data  (camera_rd_data),
        .light_output    (light_output),
        .camera_output   (camera_output)
    );

    frame_sequencer u_frame_sequencer (
        .clk_100mhz      (clk_100mhz),
        .rst             (rst),
        .s2_valid        (s2_valid),
        .s2_op           (s2_op),
        .controller_busy (controller_busy),
        .stall           (stall),
        .write_bank      (write_bank),
        .issue_bank      (issue_bank),
        .output_enabled  (output_enabled)
    );

endmodule

`default_nettype wire

//--- design/scene_pkg.sv
`default_nettype none

package scene_pkg;

    localparam int DATA_WIDTH = 16;        // One property value
    localparam int PROP_WIDTH = 4;         // Property selector
    localparam int NUM_LIGHTS_DEFAULT = 8;

    // Decoded instruction kinds
    typedef enum logic [2:0] {
        op_nop        = 3'd0,
        op_camera_set = 3'd1,
        op_light_set  = 3'd2,
        op_frame      = 3'd3,  // Swap banks, enable renderer
        op_render     = 3'd4   // Disable renderer
    } opcode_e;

    // Camera fields, in record order
    typedef enum logic [PROP_WIDTH-1:0] {
        cp_loc_x,
        cp_loc_y,
        cp_loc_z,
        cp_fwd_x,
        cp_fwd_y,
        cp_fwd_z,
        cp_up_x,
        cp_up_y,
        cp_up_z,
        cp_near_clip,
        cp_far_clip,
        cp_fov_h,
        cp_fov_v
    } cam_prop_e;

    typedef enum logic [PROP_WIDTH-1:0] {
        lp_type,     // Low two data bits only
        lp_loc_x,
        lp_loc_y,
        lp_loc_z,
        lp_fwd_x,
        lp_fwd_y,
        lp_fwd_z,
        lp_colour,
        lp_intensity
    } light_prop_e;

    typedef enum logic [1:0] {
        lt_point,
        lt_directional,
        lt_spot
    } light_type_e;

    // 13 x 16 = 208 bits, first field in the MSBs
    typedef struct packed {
        logic [DATA_WIDTH-1:0] loc_x;
        logic [DATA_WIDTH-1:0] loc_y;
        logic [DATA_WIDTH-1:0] loc_z;
        logic [DATA_WIDTH-1:0] fwd_x;
        logic [DATA_WIDTH-1:0] fwd_y;
        logic [DATA_WIDTH-1:0] fwd_z;
        logic [DATA_WIDTH-1:0] up_x;
        logic [DATA_WIDTH-1:0] up_y;
        logic [DATA_WIDTH-1:0] up_z;
        logic [DATA_WIDTH-1:0] near_clip;
        logic [DATA_WIDTH-1:0] far_clip;
        logic [DATA_WIDTH-1:0] fov_h;
        logic [DATA_WIDTH-1:0] fov_v;
    } camera_t;

    // 2 + 8 x 16 = 130 bits
    typedef struct packed {
        light_type_e           ltype;
        logic [DATA_WIDTH-1:0] loc_x;
        logic [DATA_WIDTH-1:0] loc_y;
        logic [DATA_WIDTH-1:0] loc_z;
        logic [DATA_WIDTH-1:0] fwd_x;
        logic [DATA_WIDTH-1:0] fwd_y;
        logic [DATA_WIDTH-1:0] fwd_z;
        logic [DATA_WIDTH-1:0] colour;
        logic [DATA_WIDTH-1:0] intensity;
    } light_t;

endpackage

`default_nettype wire

//--- design/scene_update_pipe.sv
`default_nettype none
`timescale 1ns/1ps

// Read in accept cycle, merge one cycle later, write the cycle after
module scene_update_pipe #(
    parameter int num_lights = scene_pkg::NUM_LIGHTS_DEFAULT
) (
    input  wire                                  clk_100mhz,
    input  wire                                  rst,
    input  wire                                  inst_valid,
    input  wire scene_pkg::opcode_e              inst_op,
    input  wire  [scene_pkg::PROP_WIDTH-1:0]     inst_prop,
    input  wire  [$clog2(num_lights)-1:0]        inst_index,
    input  wire  [scene_pkg::DATA_WIDTH-1:0]     inst_data,
    input  wire                                  stall,
    input  wire                                  issue_bank,  // Bank for a new instruction
    input  wire scene_pkg::light_t               light_rd_data,
    input  wire scene_pkg::camera_t              camera_rd_data,
    output logic                                 rd_en,
    output logic                                 rd_bank,
    output logic [$clog2(num_lights)-1:0]        rd_addr,
    output logic                                 s2_valid,
    output scene_pkg::opcode_e                   s2_op,
    output logic                                 light_we,
    output logic                                 camera_we,
    output logic                                 wr_bank,
    output logic [$clog2(num_lights)-1:0]        wr_addr,
    output scene_pkg::light_t                    light_wr_data,
    output scene_pkg::camera_t                   camera_wr_data
);

    // Merge stage
    logic [scene_pkg::PROP_WIDTH-1:0] s2_prop;
    logic [$clog2(num_lights)-1:0]    s2_index;
    logic [scene_pkg::DATA_WIDTH-1:0] s2_data;
    logic                             s2_bank;

    // Write stage
    logic                             s3_valid;
    scene_pkg::opcode_e               s3_op;
    logic [$clog2(num_lights)-1:0]    s3_index;
    logic                             s3_bank;
    scene_pkg::light_t                s3_light;
    scene_pkg::camera_t               s3_camera;

    // Record written in the cycle before, RAM read missed it
    logic                             prev_valid;
    scene_pkg::opcode_e               prev_op;
    logic [$clog2(num_lights)-1:0]    prev_index;
    logic                             prev_bank;
    scene_pkg::light_t                prev_light;
    scene_pkg::camera_t               prev_camera;

    logic               s3_hit;
    logic               prev_hit;
    scene_pkg::light_t  base_light;
    scene_pkg::light_t  merged_light;
    scene_pkg::camera_t base_camera;
    scene_pkg::camera_t merged_camera;

    assign rd_en   = inst_valid && !stall;  // Read data holds while stalled
    assign rd_bank = issue_bank;
    assign rd_addr = inst_index;            // Ignored for camera

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            s2_valid   <= 1'b0;
            s3_valid   <= 1'b0;
            prev_valid <= 1'b0;
        end else if (!stall) begin
            s2_valid   <= inst_valid;
            s3_valid   <= s2_valid;
            prev_valid <= s3_valid;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (!stall) begin
            s2_op       <= inst_op;
            s2_prop     <= inst_prop;
            s2_index    <= inst_index;
            s2_data     <= inst_data;
            s2_bank     <= issue_bank;  // Sees a swap from the merge stage
            s3_op       <= s2_op;
            s3_index    <= s2_index;
            s3_bank     <= s2_bank;
            s3_light    <= merged_light;
            s3_camera   <= merged_camera;
            prev_op     <= s3_op;
            prev_index  <= s3_index;
            prev_bank   <= s3_bank;
            prev_light  <= s3_light;
            prev_camera <= s3_camera;
        end
    end

    // Same kind, same bank, same light index
    assign s3_hit = s3_valid && s3_op == s2_op && s3_bank == s2_bank &&
                    (s2_op == scene_pkg::op_camera_set || s3_index == s2_index);
    assign prev_hit = prev_valid && prev_op == s2_op && prev_bank == s2_bank &&
                      (s2_op == scene_pkg::op_camera_set || prev_index == s2_index);

    always_comb begin
        // Newest copy wins
        base_light  = s3_hit ? s3_light : (prev_hit ? prev_light : light_rd_data);
        base_camera = s3_hit ? s3_camera : (prev_hit ? prev_camera : camera_rd_data);
        merged_light  = base_light;
        merged_camera = base_camera;

        case (scene_pkg::light_prop_e'(s2_prop))
            scene_pkg::lp_type:      merged_light.ltype = scene_pkg::light_type_e'(s2_data[1:0]);
            scene_pkg::lp_loc_x:     merged_light.loc_x     = s2_data;
            scene_pkg::lp_loc_y:     merged_light.loc_y     = s2_data;
            scene_pkg::lp_loc_z:     merged_light.loc_z     = s2_data;
            scene_pkg::lp_fwd_x:     merged_light.fwd_x     = s2_data;
            scene_pkg::lp_fwd_y:     merged_light.fwd_y     = s2_data;
            scene_pkg::lp_fwd_z:     merged_light.fwd_z     = s2_data;
            scene_pkg::lp_colour:    merged_light.colour    = s2_data;
            scene_pkg::lp_intensity: merged_light.intensity = s2_data;
            default: ;  // Unused selectors leave the record alone
        endcase

        case (scene_pkg::cam_prop_e'(s2_prop))
            scene_pkg::cp_loc_x:     merged_camera.loc_x     = s2_data;
            scene_pkg::cp_loc_y:     merged_camera.loc_y     = s2_data;
            scene_pkg::cp_loc_z:     merged_camera.loc_z     = s2_data;
            scene_pkg::cp_fwd_x:     merged_camera.fwd_x     = s2_data;
            scene_pkg::cp_fwd_y:     merged_camera.fwd_y     = s2_data;
            scene_pkg::cp_fwd_z:     merged_camera.fwd_z     = s2_data;
            scene_pkg::cp_up_x:      merged_camera.up_x      = s2_data;
            scene_pkg::cp_up_y:      merged_camera.up_y      = s2_data;
            scene_pkg::cp_up_z:      merged_camera.up_z      = s2_data;
            scene_pkg::cp_near_clip: merged_camera.near_clip = s2_data;
            scene_pkg::cp_far_clip:  merged_camera.far_clip  = s2_data;
            scene_pkg::cp_fov_h:     merged_camera.fov_h     = s2_data;
            scene_pkg::cp_fov_v:     merged_camera.fov_v     = s2_data;
            default: ;
        endcase
    end

    // One write per instruction, held back while frozen
    assign light_we  = s3_valid && s3_op == scene_pkg::op_light_set && !stall;
    assign camera_we = s3_valid && s3_op == scene_pkg::op_camera_set && !stall;
    assign wr_bank        = s3_bank;
    assign wr_addr        = s3_index;
    assign light_wr_data  = s3_light;
    assign camera_wr_data = s3_camera;

endmodule

`default_nettype wire

//--- tb/scene_memory_checker.sv
`default_nettype none
`timescale 1ns/1ps

// Protocol rules of the frame sequencer
module scene_memory_checker (
    input wire                     clk_100mhz,
    input wire                     rst,
    input wire                     s2_valid,
    input wire scene_pkg::opcode_e s2_op,
    input wire                     controller_busy,
    input wire                     stall,
    input wire                     write_bank,
    input wire                     output_enabled
);

    logic seen_frame;  // Set once the first frame has been acted on

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            seen_frame <= 1'b0;
        end else if (s2_valid && s2_op == scene_pkg::op_frame && !controller_busy) begin
            seen_frame <= 1'b1;
        end
    end

    // Stall only for a frame or render command facing a busy controller
    a_stall_cause: assert property (@(posedge clk_100mhz) disable iff (rst)
        stall |-> s2_valid && controller_busy &&
                  (s2_op == scene_pkg::op_frame || s2_op == scene_pkg::op_render))
        else $error("stall raised without a busy frame or render command");

    // Bank swap follows an unstalled frame
    a_bank_swap: assert property (@(posedge clk_100mhz) disable iff (rst)
        $changed(write_bank) |->
            $past(s2_valid && s2_op == scene_pkg::op_frame && !controller_busy))
        else $error("write_bank changed without an unstalled frame");

    a_outputs_off: assert property (@(posedge clk_100mhz) disable iff (rst)
        !seen_frame |-> !output_enabled)
        else $error("output_enabled rose before the first frame");

endmodule

bind frame_sequencer scene_memory_checker u_scene_memory_checker (
    .clk_100mhz      (clk_100mhz),
    .rst             (rst),
    .s2_valid        (s2_valid),
    .s2_op           (s2_op),
    .controller_busy (controller_busy),
    .stall           (stall),
    .write_bank      (write_bank),
    .output_enabled  (output_enabled)
);

`default_nettype wire

//--- tb/tb_scene_memory.sv
`default_nettype none
`timescale 1ns/1ps

module tb_scene_memory;

    localparam int num_lights = scene_pkg::NUM_LIGHTS_DEFAULT;
    localparam int idx_w      = $clog2(num_lights);
    localparam int dw         = scene_pkg::DATA_WIDTH;
    localparam int pw         = scene_pkg::PROP_WIDTH;
    localparam int cam_bits   = $bits(scene_pkg::camera_t);  // 208
    localparam int light_bits = $bits(scene_pkg::light_t);   // 130
    localparam int num_random = 300;
    localparam int stall_limit = 100;                         // Cycles an instruction may wait
    // Watchdog budget as the sum of per-test cycle counts
    localparam int budget_cycles = 40 + 80 + 120 + 160 + 200 + num_random * 2 + 8 * 60;
    localparam int watchdog_ns   = (budget_cycles + 500) * 10;

    logic                   clk_100mhz;
    logic                   rst;
    logic                   inst_valid;
    scene_pkg::opcode_e     inst_op;
    logic [pw-1:0]          inst_prop;
    logic [idx_w-1:0]       inst_index;
    logic [dw-1:0]          inst_data;
    logic                   controller_busy;
    logic [idx_w-1:0]       light_read_addr;
    logic                   stall;
    logic                   output_enabled;
    scene_pkg::camera_t     camera_output;
    scene_pkg::light_t      light_output;

    // Reference model holds two banks of every record
    logic [cam_bits-1:0]    cam_m [2];
    logic [light_bits-1:0]  light_m [2][num_lights];
    logic                   model_wb;
    logic                   model_oe;
    logic [31:0]            rng;
    int                     error_count;

    scene_memory u_scene_memory (
        .clk_100mhz      (clk_100mhz),
        .rst             (rst),
        .inst_valid      (inst_valid),
        .inst_op         (inst_op),
        .inst_prop       (inst_prop),
        .inst_index      (inst_index),
        .inst_data       (inst_data),
        .controller_busy (controller_busy),
        .light_read_addr (light_read_addr),
        .stall           (stall),
        .output_enabled  (output_enabled),
        .camera_output   (camera_output),
        .light_output    (light_output)
    );

    initial begin
        clk_100mhz = 1'b0;
        forever #5 clk_100mhz = ~clk_100mhz;
    end

    initial begin
        #(watchdog_ns);
        abort_run("Timeout: the tests did not finish within the expected time");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // First field sits in the MSBs
    function automatic logic [cam_bits-1:0] camera_field_set(input logic [cam_bits-1:0] rec,
                                                             input int prop,
                                                             input logic [dw-1:0] d);
        rec[cam_bits-1-dw*prop -: dw] = d;
        return rec;
    endfunction

    // Two type bits on top, then eight data fields
    function automatic logic [light_bits-1:0] light_field_set(input logic [light_bits-1:0] rec,
                                                              input int prop,
                                                              input logic [dw-1:0] d);
        if (prop == 0) begin
            rec[light_bits-1 -: 2] = d[1:0];  // Type keeps low bits only
        end else begin
            rec[light_bits-3-dw*(prop-1) -: dw] = d;
        end
        return rec;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic compare(input string test_name, input logic [255:0] expected,
                           input logic [255:0] actual);
        if (expected !== actual) begin
            error_count++;
            abort_run($sformatf("FAILED %s: expected %0h, actual %0h",
                                test_name, expected, actual));
        end
    endtask

    // Model update in acceptance order
    task automatic apply_model(input scene_pkg::opcode_e op, input int prop, input int index,
                               input logic [dw-1:0] d);
        case (op)
            scene_pkg::op_camera_set: cam_m[model_wb] = camera_field_set(cam_m[model_wb], prop, d);
            scene_pkg::op_light_set:
                light_m[model_wb][index] = light_field_set(light_m[model_wb][index], prop, d);
            scene_pkg::op_frame: begin
                model_wb = !model_wb;  // Swap without copy
                model_oe = 1'b1;
            end
            scene_pkg::op_render: model_oe = 1'b0;
            default: ;
        endcase
    endtask

    // Drives on the falling edge and holds while stalled until the accepting edge
    task automatic issue(input scene_pkg::opcode_e op, input int prop, input int index,
                         input logic [dw-1:0] d);
        int waited;
        waited = 0;
        @(negedge clk_100mhz);
        inst_valid = 1'b1;
        inst_op    = op;
        inst_prop  = prop[pw-1:0];
        inst_index = index[idx_w-1:0];
        inst_data  = d;
        #1;                                  // Let stall settle after a busy change
        while (stall) begin
            waited++;
            if (waited > stall_limit) begin
                abort_run("Stall stayed high too long, an instruction was never accepted");
            end
            @(negedge clk_100mhz);
            #1;
        end
        @(posedge clk_100mhz);
        apply_model(op, prop, index, d);
    endtask

    task automatic idle(input int cycles);
        @(negedge clk_100mhz);
        inst_valid = 1'b0;
        inst_op    = scene_pkg::op_nop;
        repeat (cycles - 1) @(negedge clk_100mhz);
    endtask

    task automatic next_data(output logic [dw-1:0] d);
        rng = xorshift32(rng);
        d   = rng[dw-1:0];
    endtask

    // Compares the display side with the model at every light address
    task automatic check_display(input string test_name);
        int a;
        compare({test_name, " output_enabled"}, model_oe, output_enabled);
        compare({test_name, " stall"}, 1'b0, stall);
        compare({test_name, " camera_output"}, cam_m[!model_wb], camera_output);
        for (a = 0; a < num_lights; a++) begin
            @(negedge clk_100mhz);
            light_read_addr = a[idx_w-1:0];
            @(negedge clk_100mhz);           // One registered read later
            compare($sformatf("%s light_output[%0d]", test_name, a),
                    light_m[!model_wb][a], light_output);
        end
    endtask

    task automatic reset_state();
        check_display("reset_state");        // All records zero and outputs off
    endtask

    task automatic frame_shows_sets();
        logic [dw-1:0] d;
        int p;
        for (p = 0; p < 13; p += 3) begin
            next_data(d);
            issue(scene_pkg::op_camera_set, p, 0, d);
        end
        for (p = 0; p < 9; p += 2) begin
            next_data(d);
            issue(scene_pkg::op_light_set, p, p % num_lights, d);
        end
        issue(scene_pkg::op_frame, 0, 0, '0);
        idle(4);
        check_display("frame_shows_sets");
    endtask

    // Back-to-back sets to one record hit both forwarding stages
    task automatic back_to_back_forwarding();
        logic [dw-1:0] d;
        int p;
        for (p = 0; p < 9; p++) begin
            next_data(d);
            issue(scene_pkg::op_light_set, p, 3, d);
        end
        next_data(d);
        issue(scene_pkg::op_light_set, 1, 3, d);  // Same field twice in a row
        next_data(d);
        issue(scene_pkg::op_light_set, 1, 3, d);
        for (p = 0; p < 13; p++) begin
            next_data(d);
            issue(scene_pkg::op_camera_set, p, 0, d);
        end
        for (p = 0; p < 6; p++) begin           // Alternating kinds use the older-write path
            next_data(d);
            issue(scene_pkg::op_light_set, 2 + p, 5, d);
            next_data(d);
            issue(scene_pkg::op_camera_set, 12 - p, 0, d);
        end
        issue(scene_pkg::op_frame, 0, 0, '0);
        idle(4);
        check_display("forwarding");
    endtask

    task automatic swap_without_copy();
        logic [dw-1:0] d;
        int p;
        for (p = 0; p < 9; p++) begin
            next_data(d);
            issue(scene_pkg::op_light_set, p, (p * 3) % num_lights, d);
            next_data(d);
            issue(scene_pkg::op_camera_set, p + 4, 0, d);
        end
        issue(scene_pkg::op_frame, 0, 0, '0);
        idle(4);
        check_display("no_copy first frame");
        issue(scene_pkg::op_frame, 0, 0, '0);  // Older bank comes back untouched
        idle(4);
        check_display("no_copy second frame");
        issue(scene_pkg::op_frame, 0, 0, '0);
        idle(4);
        check_display("no_copy third frame");
    endtask

    // Busy controller freezes the pipe and the held set goes in afterwards
    task automatic stall_then_release(input scene_pkg::opcode_e held_op, input int prop);
        logic [dw-1:0] d;
        next_data(d);
        fork
            issue(held_op, prop, 6, d);
            begin
                repeat (4) begin
                    @(negedge clk_100mhz);
                    #2;
                    compare("busy_stall stall held", 1'b1, stall);
                end
                @(negedge clk_100mhz);
                controller_busy = 1'b0;
            end
        join
    endtask

    task automatic busy_stall();
        @(negedge clk_100mhz);
        controller_busy = 1'b1;
        issue(scene_pkg::op_frame, 0, 0, '0);
        stall_then_release(scene_pkg::op_light_set, 7);
        idle(4);
        check_display("busy_stall frame");
        @(negedge clk_100mhz);
        controller_busy = 1'b1;
        issue(scene_pkg::op_render, 0, 0, '0);
        stall_then_release(scene_pkg::op_camera_set, 9);
        idle(4);
        check_display("busy_stall render");  // Outputs now off
        issue(scene_pkg::op_frame, 0, 0, '0);
        idle(4);
        check_display("busy_stall held sets");
    endtask

    task automatic random_sets();
        logic [dw-1:0] d;
        logic [31:0]   r;
        int i;
        for (i = 0; i < num_random; i++) begin
            rng = xorshift32(rng);
            r   = rng;
            next_data(d);
            if (r[3:0] == 4'd0) begin
                issue(scene_pkg::op_frame, 0, 0, '0);
            end else if (r[3:0] < 4'd11) begin
                issue(scene_pkg::op_light_set, r[15:12] % 9, r[8:6] % num_lights, d);
            end else begin
                issue(scene_pkg::op_camera_set, r[23:20] % 13, 0, d);
            end
            if (r[27:25] == 3'd0) begin
                idle(1);                     // Occasional bubble
            end
            if (i % 60 == 59) begin
                idle(4);
                check_display("random_sets");
            end
        end
        issue(scene_pkg::op_frame, 0, 0, '0);
        idle(4);
        check_display("random_sets final");
    endtask

    initial begin
        int b;
        int a;
        rst             = 1'b1;
        inst_valid      = 1'b0;
        inst_op         = scene_pkg::op_nop;
        inst_prop       = '0;
        inst_index      = '0;
        inst_data       = '0;
        controller_busy = 1'b0;
        light_read_addr = '0;
        rng             = 32'hb91dcafb;
        error_count     = 0;
        model_wb        = 1'b0;
        model_oe        = 1'b0;
        for (b = 0; b < 2; b++) begin
            cam_m[b] = '0;
            for (a = 0; a < num_lights; a++) begin
                light_m[b][a] = '0;
            end
        end
        repeat (2) @(negedge clk_100mhz);    // Two reset cycles
        rst = 1'b0;

        reset_state();
        frame_shows_sets();
        back_to_back_forwarding();
        swap_without_copy();
        busy_stall();
        random_sets();

        if (error_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "Run ended with mismatches");
        end
    end

endmodule

`default_nettype wire
